// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_riscv_dm
FILELIST  ?= riscv_dm.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) tests/tb_dm_checks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/dm_abstract_cmd.sv
// access register for x0..x31 only, 32/64-bit; postexec and other command types give cmderr 2
module dm_abstract_cmd import dm_pkg::*; import dm_core_pkg::*; #(
    parameter int DATA_SIZE = 4
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    dm_bus_if.target  bus_i,
    output logic      cmd_go_o,
    input  logic      rename_i,
    input  logic      transfer_i,
    input  xlen_t     data_pair_i,
    output logic      xfer_we_o,
    output xlen_t     xfer_wdata_o,
    output logic      xfer_size64_o,
    output logic      rnm_read_en_o,
    output logi_reg_t rnm_read_reg_o,
    input  phys_reg_t rnm_read_resp_i,
    output logic      rf_en_o,
    output phys_reg_t rf_preg_o,
    input  xlen_t     rf_rdata_i,
    output logic      rf_we_o,
    output xlen_t     rf_wdata_o
);

    cmderr_t     cmderr_q;
    logi_reg_t   regno_q;
    logic        write_q, size64_q;
    logic        cmd_wr, cmd_ok;
    logic [15:0] regno_wr;
    logic [2:0]  aarsize_wr;

    assign regno_wr   = bus_i.wdata[15:0];
    assign aarsize_wr = bus_i.wdata[CMD_AARSIZE +: 3];
    // commands are dropped while an error is pending
    assign cmd_wr     = bus_i.wr && (bus_i.addr == COMMAND) && (cmderr_q == CMDERR_NONE);
    assign cmd_ok     = (bus_i.wdata[CMD_CMDTYPE +: 8] == 8'd0)
                     && (regno_wr >= REGNO_GPR_FIRST) && (regno_wr <= REGNO_GPR_LAST)
                     && (aarsize_wr == AARSIZE_32 || aarsize_wr == AARSIZE_64)
                     && !bus_i.wdata[CMD_POSTEXEC];
    assign cmd_go_o   = cmd_wr && cmd_ok && bus_i.wdata[CMD_TRANSFER];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cmderr_q <= CMDERR_NONE;
            regno_q  <= '0;
            write_q  <= 1'b0;
            size64_q <= 1'b0;
        end else begin
            if (cmd_wr && !cmd_ok) begin
                cmderr_q <= CMDERR_NOT_SUPPORTED;
            end else if (bus_i.wr && bus_i.addr == ABSTRACTCS) begin
                cmderr_q <= cmderr_q & ~bus_i.wdata[ACS_CMDERR +: 3]; // w1c
            end
            if (cmd_go_o) begin
                regno_q  <= logi_reg_t'(regno_wr);
                write_q  <= bus_i.wdata[CMD_WRITE];
                size64_q <= (aarsize_wr == AARSIZE_64);
            end
        end
    end

    always_comb begin
        bus_i.rdata = '0; // COMMAND reads as zero
        if (bus_i.addr == ABSTRACTCS) begin
            bus_i.rdata[ACS_PROGBUFSIZE +: 5] = 5'd0;
            bus_i.rdata[ACS_CMDERR +: 3]      = cmderr_q;
            bus_i.rdata[3:0]                  = 4'(DATA_SIZE);
        end
    end

    // rename lookup spans both phases, regfile access in transfer
    assign rnm_read_en_o  = rename_i | transfer_i;
    assign rnm_read_reg_o = regno_q;
    assign rf_preg_o      = transfer_i ? rnm_read_resp_i : '0;
    assign rf_en_o        = transfer_i && !write_q;
    assign rf_we_o        = transfer_i && write_q;
    assign rf_wdata_o     = size64_q ? data_pair_i : {32'd0, data_pair_i[31:0]};

    assign xfer_we_o     = rf_en_o; // read result lands in data words
    assign xfer_wdata_o  = rf_rdata_i;
    assign xfer_size64_o = size64_q;

    // regfile access only after a rename lookup
    a_rf_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rf_en_o || rf_we_o) |-> $past(rnm_read_en_o));

endmodule

// File: design/dm_bus_if.sv
// single cycle register strobes, no handshake; a target returns zero for foreign addresses
interface dm_bus_if import dm_pkg::*; ();

    logic      rd;    // read strobe
    logic      wr;    // write strobe
    dmi_addr_t addr;
    dmi_data_t wdata;
    dmi_data_t rdata; // combinational readback

    modport ctrl (
        output rd, wr, addr, wdata,
        input  rdata
    );

    modport target (
        input  rd, wr, addr, wdata,
        output rdata
    );

endinterface

// File: design/dm_core_pkg.sv
// core side widths fixed for an rv64 core with 64 physical registers
package dm_core_pkg;

    typedef logic [63:0] xlen_t;      // register file data
    typedef logic [4:0]  logi_reg_t;  // x0..x31
    typedef logic [5:0]  phys_reg_t;
    typedef logic [31:0] data_word_t; // one dm data word

endpackage

// File: design/dm_ctrl_fsm.sv
// one request in flight; response 2 cycles after the request, 4 for an accepted command
module dm_ctrl_fsm import dm_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  dmi_addr_t req_addr_i,
    input  dmi_data_t req_data_i,
    input  dmi_op_t   req_op_i,
    output logic      resp_valid_o,
    input  logic      resp_ready_i,
    output dmi_data_t resp_data_o,
    output dmi_op_t   resp_op_o,
    dm_bus_if.ctrl    hart_bus_o,
    dm_bus_if.ctrl    data_bus_o,
    dm_bus_if.ctrl    cmd_bus_o,
    input  logic      cmd_go_i,
    output logic      rename_o,
    output logic      transfer_o
);

    dm_state_t state_q, state_d;

    dmi_addr_t addr_q;
    dmi_data_t wdata_q;
    dmi_op_t   op_q;
    dmi_data_t resp_data_q;
    dmi_op_t   resp_op_q;
    logic      rd_stb, wr_stb;
    dmi_data_t rdata_all;

    assign rd_stb    = (state_q == ACCESS) && (op_q == DMI_READ);
    assign wr_stb    = (state_q == ACCESS) && (op_q == DMI_WRITE);
    assign rdata_all = hart_bus_o.rdata | data_bus_o.rdata | cmd_bus_o.rdata;

    // same strobe on every bus, targets decode
    assign hart_bus_o.rd    = rd_stb;
    assign hart_bus_o.wr    = wr_stb;
    assign hart_bus_o.addr  = addr_q;
    assign hart_bus_o.wdata = wdata_q;
    assign data_bus_o.rd    = rd_stb;
    assign data_bus_o.wr    = wr_stb;
    assign data_bus_o.addr  = addr_q;
    assign data_bus_o.wdata = wdata_q;
    assign cmd_bus_o.rd     = rd_stb;
    assign cmd_bus_o.wr     = wr_stb;
    assign cmd_bus_o.addr   = addr_q;
    assign cmd_bus_o.wdata  = wdata_q;

    assign req_ready_o  = (state_q == IDLE);
    assign resp_valid_o = (state_q == RESPOND);
    assign resp_data_o  = resp_data_q;
    assign resp_op_o    = resp_op_q;
    assign rename_o     = (state_q == RENAME);
    assign transfer_o   = (state_q == TRANSFER);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (req_valid_i) state_d = ACCESS;
            ACCESS:   state_d = cmd_go_i ? RENAME : RESPOND;
            RENAME:   state_d = TRANSFER;
            TRANSFER: state_d = RESPOND;
            RESPOND:  if (resp_ready_i) state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request latch and response payload
    always_ff @(posedge clk_i) begin
        if (req_ready_o && req_valid_i) begin
            addr_q  <= req_addr_i;
            wdata_q <= req_data_i;
            op_q    <= req_op_i;
        end
        if (state_q == ACCESS) begin
            resp_data_q <= rd_stb ? rdata_all : '0; // writes return zero
            resp_op_q   <= (op_q == DMI_NOP || rd_stb || wr_stb) ? DMI_SUCCESS : DMI_FAILED;
        end
    end

    a_resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o)
            && $stable(resp_op_o));

    a_rename_cmd: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rename_o |-> $past(cmd_go_i) && $past(wr_stb));

    // transfer belongs to a latched COMMAND write
    a_transfer_cmd: assert property (@(posedge clk_i) disable iff (!rstn_i)
        transfer_o |-> (op_q == DMI_WRITE) && (addr_q == COMMAND));

endmodule

// File: design/dm_data_regs.sv
// data0/data1 double as the 64-bit transfer window of the abstract command
module dm_data_regs import dm_pkg::*; import dm_core_pkg::*; #(
    parameter int DATA_SIZE = 4
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    dm_bus_if.target bus_i,
    input  logic     xfer_we_i,
    input  xlen_t    xfer_wdata_i,
    input  logic     xfer_size64_i,
    output xlen_t    data_pair_o
);

    localparam int IDX_W = $clog2(DATA_SIZE);

    data_word_t       words_q [DATA_SIZE];
    logic             in_range;
    logic [IDX_W-1:0] idx;

    assign in_range = (bus_i.addr >= DATA0) && (bus_i.addr < DATA0 + 7'(DATA_SIZE));
    assign idx      = IDX_W'(bus_i.addr - DATA0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < DATA_SIZE; i++) begin
                words_q[i] <= '0;
            end
        end else if (xfer_we_i) begin
            words_q[0] <= xfer_wdata_i[31:0];
            if (xfer_size64_i) words_q[1] <= xfer_wdata_i[63:32];
        end else if (bus_i.wr && in_range) begin
            words_q[idx] <= bus_i.wdata;
        end
    end

    assign bus_i.rdata = in_range ? words_q[idx] : '0;
    assign data_pair_o = {words_q[1], words_q[0]};

    // transfer happens only after the strobe cycle of the command
    a_xfer_no_bus_wr: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(xfer_we_i && bus_i.wr));

endmodule

// File: design/dm_hart_ctrl.sv
// single hart selection only, no hart array mask; a new haltreq drops a pending resume
module dm_hart_ctrl import dm_pkg::*; #(
    parameter int NUM_HARTS = 1,
    parameter int DATA_SIZE = 4
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    dm_bus_if.target             bus_i,
    input  logic [NUM_HARTS-1:0] halted_i,
    input  logic [NUM_HARTS-1:0] running_i,
    input  logic [NUM_HARTS-1:0] resume_ack_i,
    input  logic [NUM_HARTS-1:0] havereset_i,
    input  logic [NUM_HARTS-1:0] unavail_i,
    output logic [NUM_HARTS-1:0] halt_request_o,
    output logic [NUM_HARTS-1:0] resume_request_o
);

    localparam int SEL_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

    logic [SEL_W-1:0]     hartsel_q, sel_new;
    logic [NUM_HARTS-1:0] haltreq_q, resumereq_q;
    logic                 dmactive_q;
    logic [19:0]          hartsel_wr;
    logic                 halt_new, resume_new, ctrl_wr;

    assign ctrl_wr    = bus_i.wr && (bus_i.addr == DMCONTROL);
    assign hartsel_wr = {bus_i.wdata[DMCTRL_HARTSELHI +: 10], bus_i.wdata[DMCTRL_HARTSELLO +: 10]};
    assign sel_new    = (hartsel_wr < 20'(NUM_HARTS)) ? SEL_W'(hartsel_wr) : hartsel_q;
    assign halt_new   = bus_i.wdata[DMCTRL_HALTREQ];
    assign resume_new = bus_i.wdata[DMCTRL_RESUMEREQ];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            hartsel_q   <= '0;
            haltreq_q   <= '0;
            resumereq_q <= '0;
            dmactive_q  <= 1'b0;
        end else if (ctrl_wr) begin
            hartsel_q          <= sel_new;
            haltreq_q[sel_new] <= halt_new;
            dmactive_q         <= bus_i.wdata[DMCTRL_DMACTIVE];
            if (halt_new) begin
                resumereq_q[sel_new] <= 1'b0;
            end else if (!haltreq_q[hartsel_q]) begin // old haltreq as read back
                resumereq_q[sel_new] <= resume_new;
            end
        end
    end

    assign halt_request_o   = haltreq_q;
    assign resume_request_o = resumereq_q;

    always_comb begin
        bus_i.rdata = '0;
        case (bus_i.addr)
            DMCONTROL: begin
                bus_i.rdata[DMCTRL_HALTREQ]         = haltreq_q[hartsel_q];
                bus_i.rdata[DMCTRL_HARTSELLO +: 10] = 10'(hartsel_q);
                bus_i.rdata[DMCTRL_DMACTIVE]        = dmactive_q;
            end
            DMSTATUS: begin
                bus_i.rdata[3:0]                   = DM_VERSION;
                bus_i.rdata[DMSTAT_AUTH]           = 1'b1;
                bus_i.rdata[DMSTAT_HALTED +: 2]    = {2{halted_i[hartsel_q]}};
                bus_i.rdata[DMSTAT_RUNNING +: 2]   = {2{running_i[hartsel_q]}};
                bus_i.rdata[DMSTAT_UNAVAIL +: 2]   = {2{unavail_i[hartsel_q]}};
                bus_i.rdata[DMSTAT_RESUMEACK +: 2] = {2{resume_ack_i[hartsel_q]}};
                bus_i.rdata[DMSTAT_HAVERESET +: 2] = {2{havereset_i[hartsel_q]}};
            end
            HARTINFO: begin
                bus_i.rdata[HINFO_DATASIZE +: 4] = 4'(DATA_SIZE);
                bus_i.rdata[HINFO_DATAACCESS]    = 1'b1;
            end
            default: ;
        endcase
    end

    a_halt_resume_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (halt_request_o & resume_request_o) == '0);

endmodule

// File: design/dm_pkg.sv
// debug spec 1.0 subset; only the addresses below decode, all others read zero and drop writes
package dm_pkg;

    typedef logic [6:0]  dmi_addr_t;
    typedef logic [31:0] dmi_data_t;
    typedef logic [1:0]  dmi_op_t;
    typedef logic [2:0]  cmderr_t;

    // request ops
    localparam dmi_op_t DMI_NOP   = 2'd0;
    localparam dmi_op_t DMI_READ  = 2'd1;
    localparam dmi_op_t DMI_WRITE = 2'd2;
    // response ops
    localparam dmi_op_t DMI_SUCCESS = 2'd0;
    localparam dmi_op_t DMI_FAILED  = 2'd2;

    localparam cmderr_t CMDERR_NONE          = 3'd0;
    localparam cmderr_t CMDERR_NOT_SUPPORTED = 3'd2;

    localparam dmi_addr_t DATA0      = 7'h04;
    localparam dmi_addr_t DMCONTROL  = 7'h10;
    localparam dmi_addr_t DMSTATUS   = 7'h11;
    localparam dmi_addr_t HARTINFO   = 7'h12;
    localparam dmi_addr_t ABSTRACTCS = 7'h16;
    localparam dmi_addr_t COMMAND    = 7'h17;

    localparam logic [3:0]  DM_VERSION      = 4'd3;
    localparam logic [15:0] REGNO_GPR_FIRST = 16'h1000;
    localparam logic [15:0] REGNO_GPR_LAST  = 16'h101f;
    localparam logic [2:0]  AARSIZE_32      = 3'd2;
    localparam logic [2:0]  AARSIZE_64      = 3'd3;

    // field lsb positions
    localparam int DMCTRL_HALTREQ   = 31;
    localparam int DMCTRL_RESUMEREQ = 30;
    localparam int DMCTRL_HARTSELLO = 16; // 10 bits
    localparam int DMCTRL_HARTSELHI = 6;  // 10 bits
    localparam int DMCTRL_DMACTIVE  = 0;
    localparam int DMSTAT_AUTH      = 7;
    localparam int DMSTAT_HALTED    = 8;  // any/all pairs, any in the lsb
    localparam int DMSTAT_RUNNING   = 10;
    localparam int DMSTAT_UNAVAIL   = 12;
    localparam int DMSTAT_RESUMEACK = 16;
    localparam int DMSTAT_HAVERESET = 18;
    localparam int HINFO_DATASIZE   = 12;
    localparam int HINFO_DATAACCESS = 16;
    localparam int ACS_CMDERR       = 8;
    localparam int ACS_PROGBUFSIZE  = 24;
    localparam int CMD_CMDTYPE      = 24;
    localparam int CMD_AARSIZE      = 20;
    localparam int CMD_POSTEXEC     = 18;
    localparam int CMD_TRANSFER     = 17;
    localparam int CMD_WRITE        = 16;

    typedef enum logic [2:0] {IDLE, ACCESS, RENAME, TRANSFER, RESPOND} dm_state_t;

endpackage

// File: design/riscv_dm.sv
// NUM_HARTS 1..16, DATA_SIZE 2..12; no program buffer, one DMI request in flight at a time
module riscv_dm import dm_pkg::*; import dm_core_pkg::*; #(
    parameter int NUM_HARTS = 1,
    parameter int DATA_SIZE = 4
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    // DMI request
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  dmi_addr_t            req_addr_i,
    input  dmi_data_t            req_data_i,
    input  dmi_op_t              req_op_i,
    // DMI response
    output logic                 resp_valid_o,
    input  logic                 resp_ready_i,
    output dmi_data_t            resp_data_o,
    output dmi_op_t              resp_op_o,
    // run control
    output logic [NUM_HARTS-1:0] halt_request_o,
    output logic [NUM_HARTS-1:0] resume_request_o,
    input  logic [NUM_HARTS-1:0] halted_i,
    input  logic [NUM_HARTS-1:0] running_i,
    input  logic [NUM_HARTS-1:0] resume_ack_i,
    input  logic [NUM_HARTS-1:0] havereset_i,
    input  logic [NUM_HARTS-1:0] unavail_i,
    // rename table and register file
    output logic                 rnm_read_en_o,
    output logi_reg_t            rnm_read_reg_o,
    input  phys_reg_t            rnm_read_resp_i,
    output logic                 rf_en_o,
    output phys_reg_t            rf_preg_o,
    input  xlen_t                rf_rdata_i,
    output logic                 rf_we_o,
    output xlen_t                rf_wdata_o
);

    dm_bus_if hart_bus ();
    dm_bus_if data_bus ();
    dm_bus_if cmd_bus ();

    logic  cmd_go;
    logic  rename;
    logic  transfer;
    logic  xfer_we;
    logic  xfer_size64;
    xlen_t xfer_wdata;
    xlen_t data_pair; // data1:data0

    dm_ctrl_fsm u_ctrl_fsm (
        .clk_i, .rstn_i,
        .req_valid_i, .req_ready_o, .req_addr_i, .req_data_i, .req_op_i,
        .resp_valid_o, .resp_ready_i, .resp_data_o, .resp_op_o,
        .hart_bus_o (hart_bus.ctrl),
        .data_bus_o (data_bus.ctrl),
        .cmd_bus_o  (cmd_bus.ctrl),
        .cmd_go_i   (cmd_go),
        .rename_o   (rename),
        .transfer_o (transfer)
    );

    dm_hart_ctrl #(.NUM_HARTS(NUM_HARTS), .DATA_SIZE(DATA_SIZE)) u_hart_ctrl (
        .clk_i, .rstn_i,
        .bus_i (hart_bus.target),
        .halted_i, .running_i, .resume_ack_i, .havereset_i, .unavail_i,
        .halt_request_o, .resume_request_o
    );

    dm_data_regs #(.DATA_SIZE(DATA_SIZE)) u_data_regs (
        .clk_i, .rstn_i,
        .bus_i         (data_bus.target),
        .xfer_we_i     (xfer_we),
        .xfer_wdata_i  (xfer_wdata),
        .xfer_size64_i (xfer_size64),
        .data_pair_o   (data_pair)
    );

    dm_abstract_cmd #(.DATA_SIZE(DATA_SIZE)) u_abstract_cmd (
        .clk_i, .rstn_i,
        .bus_i         (cmd_bus.target),
        .cmd_go_o      (cmd_go),
        .rename_i      (rename),
        .transfer_i    (transfer),
        .data_pair_i   (data_pair),
        .xfer_we_o     (xfer_we),
        .xfer_wdata_o  (xfer_wdata),
        .xfer_size64_o (xfer_size64),
        .rnm_read_en_o, .rnm_read_reg_o, .rnm_read_resp_i,
        .rf_en_o, .rf_preg_o, .rf_rdata_i, .rf_we_o, .rf_wdata_o
    );

endmodule

// File: riscv_dm.f
design/dm_pkg.sv
design/dm_core_pkg.sv
design/dm_bus_if.sv
design/dm_ctrl_fsm.sv
design/dm_hart_ctrl.sv
design/dm_data_regs.sv
design/dm_abstract_cmd.sv
design/riscv_dm.sv
+incdir+tests
tests/tb_riscv_dm.sv

// File: tests/tb_dm_checks.svh
// expects the model state and hart inputs of tb_riscv_dm in scope; DATA_SIZE 4 and 4 harts only

// galois lfsr, taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_q[0]};
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return v;
endfunction

// expected read data from the model state
function automatic dmi_data_t ref_read(input dmi_addr_t addr);
    dmi_data_t d;
    d = '0;
    if (addr >= DATA0 && addr < DATA0 + 7'd4) begin
        d = exp_words[2'(addr - DATA0)];
    end else if (addr == DMCONTROL) begin
        d = {exp_halt[exp_sel], 5'd0, 8'd0, exp_sel, 15'd0, exp_active};
    end else if (addr == DMSTATUS) begin
        d[3:0]   = 4'd3;
        d[7]     = 1'b1;
        d[9:8]   = {2{halted_i[exp_sel]}};
        d[11:10] = {2{running_i[exp_sel]}};
        d[13:12] = {2{unavail_i[exp_sel]}};
        d[17:16] = {2{resume_ack_i[exp_sel]}};
        d[19:18] = {2{havereset_i[exp_sel]}};
    end else if (addr == HARTINFO) begin
        d = (32'd4 << 12) | (32'd1 << 16);
    end else if (addr == ABSTRACTCS) begin
        d = {21'd0, exp_cmderr, 8'd4};
    end
    return d;
endfunction

// applies one DMI write to the model
task automatic model_write(input dmi_addr_t addr, input dmi_data_t w);
    logic [19:0] hs;
    logic [5:0]  p;
    logic        ok;
    if (addr >= DATA0 && addr < DATA0 + 7'd4) begin
        exp_words[2'(addr - DATA0)] = w;
    end else if (addr == DMCONTROL) begin
        hs = {w[15:6], w[25:16]};
        if (w[31]) begin
            exp_resume[(hs < 20'd4) ? hs[1:0] : exp_sel] = 1'b0;
        end else if (!exp_halt[exp_sel]) begin
            exp_resume[(hs < 20'd4) ? hs[1:0] : exp_sel] = w[30];
        end
        if (hs < 20'd4) exp_sel = hs[1:0];
        exp_halt[exp_sel] = w[31];
        exp_active = w[0];
    end else if (addr == ABSTRACTCS) begin
        exp_cmderr = exp_cmderr & ~w[10:8];
    end else if (addr == COMMAND && exp_cmderr == 3'd0) begin
        ok = (w[31:24] == 8'd0) && (w[15:0] >= 16'h1000) && (w[15:0] <= 16'h101f)
            && (w[22:20] == 3'd2 || w[22:20] == 3'd3) && !w[18];
        p = {1'b0, w[4:0]} + 6'd16; // rename map r -> r+16
        if (!ok) begin
            exp_cmderr = 3'd2;
        end else if (w[17] && w[16]) begin
            exp_rf[p] = (w[22:20] == 3'd3) ? {exp_words[1], exp_words[0]}
                                           : {32'd0, exp_words[0]};
        end else if (w[17]) begin
            exp_words[0] = exp_rf[p][31:0];
            if (w[22:20] == 3'd3) exp_words[1] = exp_rf[p][63:32];
        end
    end
endtask

task automatic check_data(input string name, input dmi_data_t exp, input dmi_data_t act);
    if (exp !== act) stop_on_error($sformatf("Mismatch %s exp %h act %h", name, exp, act));
endtask

task automatic check_op(input string name, input dmi_op_t exp, input dmi_op_t act);
    if (exp !== act) stop_on_error($sformatf("Mismatch %s exp %h act %h", name, exp, act));
endtask

task automatic check_reg(input string name, input xlen_t exp, input xlen_t act);
    if (exp !== act) stop_on_error($sformatf("Mismatch %s exp %h act %h", name, exp, act));
endtask

task automatic check_cmderr(input string name, input cmderr_t exp, input cmderr_t act);
    if (exp !== act) stop_on_error($sformatf("Mismatch %s exp %h act %h", name, exp, act));
endtask

// File: tests/tb_riscv_dm.sv
// 4 harts, 4 data words; register file model renames xN to physical N+16
module tb_riscv_dm import dm_pkg::*; import dm_core_pkg::*; ;

    localparam int NUM_REQS = 54;
    localparam int TIMEOUT  = 40 * NUM_REQS;

    logic clk_i = 1'b0, rstn_i = 1'b0;
    logic req_valid_i = 1'b0, req_ready_o, resp_valid_o, resp_ready_i = 1'b0;
    dmi_addr_t req_addr_i = '0;
    dmi_data_t req_data_i = '0, resp_data_o;
    dmi_op_t req_op_i = '0, resp_op_o;
    logic [3:0] halt_request_o, resume_request_o;
    logic [3:0] halted_i = '0, running_i = '0, resume_ack_i = '0, havereset_i = '0, unavail_i = '0;
    logic rnm_read_en_o, rf_en_o, rf_we_o;
    logi_reg_t rnm_read_reg_o;
    phys_reg_t rnm_read_resp_i = '0, rf_preg_o;
    xlen_t rf_rdata_i, rf_wdata_o;

    logic [31:0] lfsr_q = 32'h2c3062e4;
    xlen_t       rf_mem [64];
    xlen_t       exp_rf [64];
    data_word_t  exp_words [4];
    logic [3:0]  exp_halt = '0, exp_resume = '0;
    logic [1:0]  exp_sel = '0;
    logic        exp_active = 1'b0;
    cmderr_t     exp_cmderr = '0;
    dmi_data_t   exp_data_q [$];
    dmi_op_t     exp_op_q [$];
    dmi_addr_t   rd_addr_q [$];
    string       name_q [$];
    int          req_cnt = 0, resp_cnt = 0, cycles = 0;

    `include "tb_dm_checks.svh"

    always #5 clk_i = ~clk_i;

    riscv_dm #(.NUM_HARTS(4), .DATA_SIZE(4)) u_riscv_dm (.*);

    // rename table answers one cycle later, register file reads combinationally
    always @(posedge clk_i) begin
        if (rnm_read_en_o) rnm_read_resp_i <= #1 phys_reg_t'({1'b0, rnm_read_reg_o}) + 6'd16;
        if (rf_we_o) rf_mem[rf_preg_o] <= rf_wdata_o;
    end
    assign rf_rdata_i = rf_en_o ? rf_mem[rf_preg_o] : '0; // data only while read enabled

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > TIMEOUT) stop_on_error("timeout, DUT stopped answering DMI requests");
    end

    // response monitor
    always @(posedge clk_i) begin
        if (rstn_i && resp_valid_o && resp_ready_i) begin
            if (exp_data_q.size() == 0) begin
                stop_on_error("response arrived without a request");
            end else begin
                if (rd_addr_q[0] == ABSTRACTCS) begin
                    check_cmderr(name_q[0], exp_cmderr, resp_data_o[10:8]);
                end
                check_data(name_q[0], exp_data_q[0], resp_data_o);
                check_op(name_q[0], exp_op_q[0], resp_op_o);
                void'(exp_data_q.pop_front());
                void'(exp_op_q.pop_front());
                void'(rd_addr_q.pop_front());
                void'(name_q.pop_front());
                resp_cnt++;
            end
        end
    end

    task automatic dmi_req(input dmi_op_t op, input dmi_addr_t addr, input dmi_data_t w,
                           input string name);
        exp_data_q.push_back(op == DMI_READ ? ref_read(addr) : '0);
        exp_op_q.push_back(op == 2'd3 ? DMI_FAILED : DMI_SUCCESS);
        rd_addr_q.push_back(op == DMI_READ ? addr : 7'h7f);
        name_q.push_back(name);
        if (op == DMI_WRITE) model_write(addr, w);
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_data_i  = w;
        @(posedge clk_i);
        while (!req_ready_o) @(posedge clk_i);
        #1 req_valid_i = 1'b0;
        req_cnt++;
        wait (resp_cnt == req_cnt);
    endtask

    function automatic dmi_data_t dmctl(input logic halt, input logic res, input logic [19:0] sel);
        return {halt, res, 4'd0, sel[9:0], sel[19:10], 5'd0, 1'b1};
    endfunction

    initial begin
        dmi_data_t bad [3];
        for (int i = 0; i < 64; i++) begin
            rf_mem[i] = {rand_bits(32), rand_bits(32)};
            exp_rf[i] = rf_mem[i];
        end
        for (int i = 0; i < 4; i++) exp_words[i] = '0;
        repeat (5) @(posedge clk_i);
        #1 rstn_i = 1'b1;
        resp_ready_i = 1'b1;
        // data words, nop and reserved op
        for (int i = 0; i < 4; i++) dmi_req(DMI_WRITE, DATA0 + 7'(i), rand_bits(32), "data_wr");
        for (int i = 0; i < 4; i++) dmi_req(DMI_READ, DATA0 + 7'(i), '0, "data_rd");
        dmi_req(DMI_NOP, DATA0, '0, "nop");
        dmi_req(2'd3, DATA0, '0, "reserved_op");
        // hart selection, halt and resume requests
        dmi_req(DMI_WRITE, DMCONTROL, dmctl(1, 0, 2), "halt_h2");
        check_data("halt_req", dmi_data_t'(exp_halt), dmi_data_t'(halt_request_o));
        dmi_req(DMI_WRITE, DMCONTROL, dmctl(1, 0, 5), "bad_hartsel");
        dmi_req(DMI_READ, DMCONTROL, '0, "dmcontrol_rd");
        dmi_req(DMI_WRITE, DMCONTROL, dmctl(1, 1, 1), "halt_resume_h1");
        dmi_req(DMI_WRITE, DMCONTROL, dmctl(0, 0, 3), "sel_h3");
        dmi_req(DMI_WRITE, DMCONTROL, dmctl(0, 1, 3), "resume_h3");
        check_data("halt_req", dmi_data_t'(exp_halt), dmi_data_t'(halt_request_o));
        check_data("resume_req", dmi_data_t'(exp_resume), dmi_data_t'(resume_request_o));
        // status readback per hart
        @(posedge clk_i);
        #1;
        {halted_i, running_i, resume_ack_i} = 12'(rand_bits(12));
        {havereset_i, unavail_i} = 8'(rand_bits(8));
        for (int h = 0; h < 4; h++) begin
            dmi_req(DMI_WRITE, DMCONTROL, dmctl(0, 0, 20'(h)), "sel_hart");
            dmi_req(DMI_READ, DMSTATUS, '0, "dmstatus_rd");
        end
        dmi_req(DMI_READ, HARTINFO, '0, "hartinfo_rd");
        dmi_req(DMI_READ, ABSTRACTCS, '0, "abstractcs_rd");
        // abstract reads, 64 then 32 bit
        dmi_req(DMI_WRITE, COMMAND, 32'h0032_1005, "cmd_rd64_x5");
        dmi_req(DMI_READ, DATA0, '0, "xfer_data0");
        dmi_req(DMI_READ, DATA0 + 7'd1, '0, "xfer_data1");
        dmi_req(DMI_WRITE, COMMAND, 32'h0022_1007, "cmd_rd32_x7");
        dmi_req(DMI_READ, DATA0, '0, "xfer_data0");
        dmi_req(DMI_READ, DATA0 + 7'd1, '0, "xfer_data1");
        // abstract writes
        dmi_req(DMI_WRITE, DATA0, rand_bits(32), "data0_wr");
        dmi_req(DMI_WRITE, DATA0 + 7'd1, rand_bits(32), "data1_wr");
        dmi_req(DMI_WRITE, COMMAND, 32'h0033_1009, "cmd_wr64_x9");
        check_reg("rf_x9", exp_rf[25], rf_mem[25]);
        dmi_req(DMI_WRITE, COMMAND, 32'h0023_100a, "cmd_wr32_x10");
        check_reg("rf_x10", exp_rf[26], rf_mem[26]);
        // unsupported commands, sticky cmderr
        bad[0] = 32'h0032_1020;
        bad[1] = 32'h0042_1005;
        bad[2] = 32'h0036_1005;
        for (int i = 0; i < 3; i++) begin
            dmi_req(DMI_WRITE, COMMAND, bad[i], "bad_cmd");
            dmi_req(DMI_READ, ABSTRACTCS, '0, "cmderr_set");
            dmi_req(DMI_WRITE, COMMAND, 32'h0032_100c, "ignored_cmd");
            dmi_req(DMI_READ, DATA0, '0, "ignored_data0");
            dmi_req(DMI_WRITE, ABSTRACTCS, 32'h0000_0700, "cmderr_clr");
            dmi_req(DMI_READ, ABSTRACTCS, '0, "cmderr_clr_rd");
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
